/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ntsc_capture
FILELIST  = project.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/ccir656_sync_fsm.sv */
`timescale 1ns/100ps
`include "ntsc_params.svh"

module ccir656_sync_fsm
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`CCIR_W-1:0]    i_video,
   output logic                  o_y_en,
   output logic                  o_cr_en,
   output logic                  o_cb_en,
   output ntsc_pkg::vid_timing_t o_timing
);
   import ntsc_pkg::*;

   sync_state_t state;
   sync_state_t state_nxt;
   logic        is_ff;
   logic        xy_known;
   logic        xy_hit;
   logic        field;

   // A 3FF inside the sample run means a new preamble has begun
   assign is_ff = (i_video == `CODE_FF);

   // Only the eight legal XY words count as timing codes
   always_comb
   begin
      case (i_video)
         `XY_SAV_F1, `XY_EAV_F1, `XY_SAV_VBI_F1, `XY_EAV_VBI_F1,
         `XY_SAV_F2, `XY_EAV_F2, `XY_SAV_VBI_F2, `XY_EAV_VBI_F2:
            xy_known = 1'b1;
         default:
            xy_known = 1'b0;
      endcase
   end

   assign xy_hit = (state == SYNC_3) && xy_known;

   //////////////////////////////////////////////////
   // Next state
   //////////////////////////////////////////////////

   always_comb
   begin
      state_nxt = SYNC_1;
      case (state)
         // SYNC_1 also absorbs the 3FF itself, waits for two zeros
         SYNC_1: state_nxt = (i_video == `CODE_00) ? SYNC_2 : SYNC_1;
         SYNC_2: state_nxt = (i_video == `CODE_00) ? SYNC_3 : SYNC_1;
         SYNC_3:
         begin
            // EAV and VBI codes carry no samples, back to hunting
            case (i_video)
               `XY_SAV_F1: state_nxt = F1_CB;
               `XY_SAV_F2: state_nxt = F2_CB;
               default:    state_nxt = SYNC_1;
            endcase
         end
         F1_CB:   state_nxt = is_ff ? SYNC_1 : F1_Y0;
         F1_Y0:   state_nxt = is_ff ? SYNC_1 : F1_CR;
         F1_CR:   state_nxt = is_ff ? SYNC_1 : F1_Y1;
         F1_Y1:   state_nxt = is_ff ? SYNC_1 : F1_CB;
         F2_CB:   state_nxt = is_ff ? SYNC_1 : F2_Y0;
         F2_Y0:   state_nxt = is_ff ? SYNC_1 : F2_CR;
         F2_CR:   state_nxt = is_ff ? SYNC_1 : F2_Y1;
         F2_Y1:   state_nxt = is_ff ? SYNC_1 : F2_CB;
         default: state_nxt = SYNC_1;
      endcase
   end

   // State register and field level
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= SYNC_1;
         field <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (xy_hit)
         begin
            field <= i_video[`XY_F_BIT];
         end
      end
   end

   //////////////////////////////////////////////////
   // Component strobes and timing pulses
   //////////////////////////////////////////////////

   // Strobe follows the current word, suppressed on an abort
   assign o_cb_en = ((state == F1_CB) || (state == F2_CB)) && !is_ff;
   assign o_cr_en = ((state == F1_CR) || (state == F2_CR)) && !is_ff;
   assign o_y_en  = ((state == F1_Y0) || (state == F1_Y1) ||
                     (state == F2_Y0) || (state == F2_Y1)) && !is_ff;

   // v and h are live only during a recognised XY word
   always_comb
   begin
      o_timing.f = field;
      o_timing.v = xy_hit && i_video[`XY_V_BIT];
      o_timing.h = xy_hit && i_video[`XY_H_BIT];
   end

endmodule

/* hw/ntsc_capture_top.sv */
`timescale 1ns/100ps
`include "ntsc_params.svh"

module ntsc_capture_top
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`CCIR_W-1:0]   i_video,
   output ntsc_pkg::pair_word_t o_pair,
   output logic                 o_pair_valid,
   output logic                 o_frame_start
);
   import ntsc_pkg::*;

   // Decoder to capture strobes
   logic                y_en;
   logic                cr_en;
   logic                cb_en;
   vid_timing_t         timing;
   // Assembled sample and raster position
   ycrcb_t              sample;
   logic                sample_valid;
   logic [`COL_W-1:0]   raster_col;
   logic [`LINE_W-1:0]  raster_line;

   //////////////////////////////////////////////////
   // Decode, capture, count, pack
   //////////////////////////////////////////////////

   ccir656_sync_fsm u_sync
   (
      .clk      (clk),
      .reset    (reset),
      .i_video  (i_video),
      .o_y_en   (y_en),
      .o_cr_en  (cr_en),
      .o_cb_en  (cb_en),
      .o_timing (timing)
   );

   ycrcb_capture u_capture
   (
      .clk            (clk),
      .reset          (reset),
      .i_y_en         (y_en),
      .i_cr_en        (cr_en),
      .i_cb_en        (cb_en),
      .i_video        (i_video),
      .o_sample       (sample),
      .o_sample_valid (sample_valid)
   );

   raster_counter u_raster
   (
      .clk            (clk),
      .reset          (reset),
      .i_timing       (timing),
      .i_sample_valid (sample_valid),
      .o_col          (raster_col),
      .o_line         (raster_line),
      .o_frame_start  (o_frame_start)
   );

   // Line end is the raw h pulse
   pixel_pair_packer u_packer
   (
      .clk            (clk),
      .reset          (reset),
      .i_sample       (sample),
      .i_sample_valid (sample_valid),
      .i_col          (raster_col),
      .i_line         (raster_line),
      .i_line_end     (timing.h),
      .o_pair         (o_pair),
      .o_pair_valid   (o_pair_valid)
   );

endmodule

/* hw/ntsc_params.svh */
`ifndef NTSC_PARAMS_SVH
`define NTSC_PARAMS_SVH

//////////////////////////////////////////////////
// Stream format
//////////////////////////////////////////////////

// One 10-bit word per line clock
`define CCIR_W          10

// Timing reference preamble, 3FF 000 000 XY
`define CODE_FF         10'h3FF
`define CODE_00         10'h000

// XY words for field bit 0
`define XY_SAV_F1       10'h200
`define XY_EAV_F1       10'h274
`define XY_SAV_VBI_F1   10'h2AC
`define XY_EAV_VBI_F1   10'h2D8

// XY words for field bit 1
`define XY_SAV_F2       10'h31C
`define XY_EAV_F2       10'h368
`define XY_SAV_VBI_F2   10'h3B0
`define XY_EAV_VBI_F2   10'h3C4

// Field, vertical and horizontal bits inside XY
`define XY_F_BIT        8
`define XY_V_BIT        7
`define XY_H_BIT        6

//////////////////////////////////////////////////
// Raster and pixel sizes
//////////////////////////////////////////////////

`define COL_W           10
`define LINE_W          9

// Active window, lines 25..504 and the first 640 columns
`define ACTIVE_COLS     10'd640
`define FIRST_LINE      9'd25
`define END_LINE        9'd505

// Interlaced, so each field advances two frame lines
`define LINE_STEP       9'd2

// Truncated pixel, 8-bit luma and 5-bit chroma
`define PIX_Y_W         8
`define PIX_C_W         5

`endif

/* hw/ntsc_pkg.sv */
`include "ntsc_params.svh"

package ntsc_pkg;

   //////////////////////////////////////////////////
   // Decoder FSM states
   //////////////////////////////////////////////////

   // SYNC_x walk the preamble, Fn_* walk Cb Y Cr Y per field
   typedef enum logic [3:0]
   {
      SYNC_1,
      SYNC_2,
      SYNC_3,
      F1_CB,
      F1_Y0,
      F1_CR,
      F1_Y1,
      F2_CB,
      F2_Y0,
      F2_CR,
      F2_Y1
   } sync_state_t;

   // Full precision sample, luma in the top bits
   typedef struct packed
   {
      logic [`CCIR_W-1:0] y;
      logic [`CCIR_W-1:0] cr;
      logic [`CCIR_W-1:0] cb;
   } ycrcb_t;

   // f is a level, v and h are single cycle pulses
   typedef struct packed
   {
      logic f;
      logic v;
      logic h;
   } vid_timing_t;

   // 8/5/5 truncated pixel
   typedef struct packed
   {
      logic [`PIX_Y_W-1:0] y8;
      logic [`PIX_C_W-1:0] cr5;
      logic [`PIX_C_W-1:0] cb5;
   } pixel18_t;

   // Two pixels tagged with the column of pix1 and the window-relative line
   typedef struct packed
   {
      pixel18_t           pix0;
      pixel18_t           pix1;
      logic [`COL_W-1:0]  col;
      logic [`LINE_W-1:0] line;
   } pair_word_t;

endpackage

/* hw/pixel_pair_packer.sv */
`timescale 1ns/100ps
`include "ntsc_params.svh"

module pixel_pair_packer
(
   input  logic                 clk,
   input  logic                 reset,
   input  ntsc_pkg::ycrcb_t     i_sample,
   input  logic                 i_sample_valid,
   input  logic [`COL_W-1:0]    i_col,
   input  logic [`LINE_W-1:0]   i_line,
   input  logic                 i_line_end,
   output ntsc_pkg::pair_word_t o_pair,
   output logic                 o_pair_valid
);
   import ntsc_pkg::*;

   logic     in_window;
   logic     take;
   logic     phase;
   pixel18_t pix_now;
   pixel18_t pix_first;

   // Keep the top bits of each component
   function automatic pixel18_t trunc_pixel(input ycrcb_t s);
      pixel18_t p;
      p.y8  = s.y[`CCIR_W-1 -: `PIX_Y_W];
      p.cr5 = s.cr[`CCIR_W-1 -: `PIX_C_W];
      p.cb5 = s.cb[`CCIR_W-1 -: `PIX_C_W];
      return p;
   endfunction

   // Visible area only, blanking and overscan are dropped
   assign in_window = (i_line >= `FIRST_LINE) && (i_line < `END_LINE) &&
                      (i_col < `ACTIVE_COLS);
   assign take      = i_sample_valid && in_window;
   assign pix_now   = trunc_pixel(i_sample);

   //////////////////////////////////////////////////
   // Pair phase and output strobe
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase        <= 1'b0;
         o_pair_valid <= 1'b0;
      end
      else
      begin
         o_pair_valid <= take && phase;
         // Each line starts on an even pixel
         if (i_line_end)
         begin
            phase <= 1'b0;
         end
         else if (take)
         begin
            phase <= ~phase;
         end
      end
   end

   // First pixel parks here, the second builds the word
   always_ff @(posedge clk)
   begin
      if (take && !phase)
      begin
         pix_first <= pix_now;
      end
      if (take && phase)
      begin
         o_pair.pix0 <= pix_first;
         o_pair.pix1 <= pix_now;
         o_pair.col  <= i_col;
         o_pair.line <= i_line - `FIRST_LINE;
      end
   end

endmodule

/* hw/raster_counter.sv */
`timescale 1ns/100ps
`include "ntsc_params.svh"

module raster_counter
(
   input  logic                  clk,
   input  logic                  reset,
   input  ntsc_pkg::vid_timing_t i_timing,
   input  logic                  i_sample_valid,
   output logic [`COL_W-1:0]     o_col,
   output logic [`LINE_W-1:0]    o_line,
   output logic                  o_frame_start
);

   // v pulse delayed one cycle, f has taken the new field bit by then
   logic v_q;
   // Frame marker may fire, cleared once it has
   logic armed;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         v_q <= 1'b0;
      end
      else
      begin
         v_q <= i_timing.v;
      end
   end

   //////////////////////////////////////////////////
   // Column and line counters
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         o_col  <= '0;
         o_line <= '0;
      end
      else if (v_q)
      begin
         // Field start, line parity comes from the field bit
         o_col  <= '0;
         o_line <= {{(`LINE_W-1){1'b0}}, i_timing.f};
      end
      else if (i_timing.h && !i_timing.v)
      begin
         // Line end, skip over the other field's line
         o_col  <= '0;
         o_line <= o_line + `LINE_STEP;
      end
      else if (i_timing.h || i_timing.v)
      begin
         // v wins on EAV_VBI, line is reloaded next cycle
         o_col <= '0;
      end
      else if (i_sample_valid)
      begin
         o_col <= o_col + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Frame start marker
   //////////////////////////////////////////////////

   // First vertical code with f set, one cycle after the XY word
   assign o_frame_start = v_q && i_timing.f && armed;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         armed <= 1'b1;
      end
      else if (o_frame_start)
      begin
         armed <= 1'b0;
      end
      else if (!i_timing.f)
      begin
         // Any code with f clear re-arms
         armed <= 1'b1;
      end
   end

endmodule

/* hw/ycrcb_capture.sv */
`timescale 1ns/100ps
`include "ntsc_params.svh"

module ycrcb_capture
(
   input  logic                clk,
   input  logic                reset,
   input  logic                i_y_en,
   input  logic                i_cr_en,
   input  logic                i_cb_en,
   input  logic [`CCIR_W-1:0]  i_video,
   output ntsc_pkg::ycrcb_t    o_sample,
   output logic                o_sample_valid
);

   // Component holding registers
   // Cb and Cr stay put across both Y words of a pair
   always_ff @(posedge clk)
   begin
      if (i_y_en)
      begin
         o_sample.y <= i_video;
      end
      if (i_cr_en)
      begin
         o_sample.cr <= i_video;
      end
      if (i_cb_en)
      begin
         o_sample.cb <= i_video;
      end
   end

   // Valid lines up with the freshly loaded Y
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         o_sample_valid <= 1'b0;
      end
      else
      begin
         o_sample_valid <= i_y_en;
      end
   end

endmodule

/* project.f */
+incdir+hw
+incdir+sim
hw/ntsc_pkg.sv
hw/ccir656_sync_fsm.sv
hw/ycrcb_capture.sv
hw/raster_counter.sv
hw/pixel_pair_packer.sv
hw/ntsc_capture_top.sv
sim/tb_clkgen.sv
sim/ntsc_capture_chk.sv
sim/tb_ntsc_capture.sv

/* sim/ntsc_capture_chk.sv */
`timescale 1ns/100ps

module ntsc_capture_chk
(
   input logic clk,
   input logic reset,
   input logic i_pair_valid,
   input logic i_frame_start
);

   // Count of failed assertions
   int failures = 0;

   // Outputs quiet on the cycle after each reset edge
   a_reset_quiet: assert property (@(posedge clk) reset |=> (!i_pair_valid && !i_frame_start))
      else
      begin
         failures++;
         $error("pair or frame output active during reset");
      end

   // A pair needs four stream words and so never comes back to back
   a_pair_gap: assert property (@(posedge clk) disable iff (reset)
                                i_pair_valid |=> !i_pair_valid)
      else
      begin
         failures++;
         $error("o_pair_valid high on two consecutive cycles");
      end

   // Marker is a single cycle pulse
   a_marker_gap: assert property (@(posedge clk) disable iff (reset)
                                  i_frame_start |=> !i_frame_start)
      else
      begin
         failures++;
         $error("o_frame_start high on two consecutive cycles");
      end

endmodule

/* sim/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen
(
   output logic o_clk,
   output logic o_reset
);

   // 20 ns period
   initial
   begin
      o_clk = 1'b0;
      forever
      begin
         #10 o_clk = ~o_clk;
      end
   end

   // Reset held for the first 10 rising edges
   initial
   begin
      o_reset = 1'b1;
      repeat (10) @(posedge o_clk);
      o_reset <= 1'b0;
   end

endmodule

/* sim/tb_video_model.svh */
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

//////////////////////////////////////////////////
// Random source
//////////////////////////////////////////////////

logic [31:0] lcg_state = 32'h9760_9ddd;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Data words keep clear of 000 and 3FF
function automatic logic [9:0] rand_data();
   logic [31:0] r;
   r = lcg_next();
   return 10'(32'd1 + ({8'd0, r[31:8]} % 32'd1022));
endfunction

function automatic int rand_range(input int lo, input int hi);
   logic [31:0] r;
   r = lcg_next();
   return lo + int'({8'd0, r[31:8]} % 32'(hi - lo + 1));
endfunction

//////////////////////////////////////////////////
// Reference model of raster, pairs and markers
//////////////////////////////////////////////////

logic [`LINE_W-1:0] m_line  = '0;
logic [`COL_W-1:0]  m_col   = '0;
logic               m_phase = 1'b0;
logic               m_field = 1'b0;
logic               m_armed = 1'b1;
logic [9:0]         m_cb    = '0;
logic [9:0]         m_cr    = '0;
pixel18_t           m_first;
int                 m_markers = 0;
pair_word_t         exp_q[$];

// Top 8 bits of luma, top 5 of each chroma
function automatic pixel18_t make_pixel(input logic [9:0] y, input logic [9:0] cr,
                                        input logic [9:0] cb);
   pixel18_t p;
   p.y8  = y[9:2];
   p.cr5 = cr[9:5];
   p.cb5 = cb[9:5];
   return p;
endfunction

// Timing code effect on field, marker arm and counters
task automatic model_code(input logic [9:0] xy);
   m_field = xy[8];
   if (!m_field)
   begin
      m_armed = 1'b1;
   end
   if (xy[7] && m_field && m_armed)
   begin
      m_markers++;
      m_armed = 1'b0;
   end
   if (xy[6])
   begin
      m_phase = 1'b0;
      m_col   = '0;
   end
   // v reloads the line from the field bit, h alone steps it
   if (xy[7])
   begin
      m_col  = '0;
      m_line = {{(`LINE_W-1){1'b0}}, m_field};
   end
   else if (xy[6])
   begin
      m_line = m_line + `LINE_STEP;
   end
endtask

// One assembled sample, Cr may still be the previous group's
task automatic model_sample(input logic [9:0] y);
   pixel18_t   p;
   pair_word_t w;
   p = make_pixel(y, m_cr, m_cb);
   if ((m_line >= `FIRST_LINE) && (m_line < `END_LINE) && (m_col < `ACTIVE_COLS))
   begin
      if (m_phase)
      begin
         w.pix0 = m_first;
         w.pix1 = p;
         w.col  = m_col;
         w.line = m_line - `FIRST_LINE;
         exp_q.push_back(w);
      end
      else
      begin
         m_first = p;
      end
      m_phase = !m_phase;
   end
   m_col = m_col + 1'b1;
endtask

// Word k of the Cb Y Cr Y run
task automatic model_word(input int k, input logic [9:0] w);
   case (k % 4)
      0: m_cb = w;
      2: m_cr = w;
      default: model_sample(w);
   endcase
endtask

`endif

/* sim/tb_ntsc_capture.sv */
`timescale 1ns/100ps
`include "ntsc_params.svh"

module tb_ntsc_capture;
   import ntsc_pkg::*;

   logic               clk;
   logic               reset;
   logic [`CCIR_W-1:0] video;
   pair_word_t         pair;
   logic               pair_valid;
   logic               frame_start;

   // Run bookkeeping
   int errors       = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int got_markers  = 0;
   int got_pairs    = 0;

   `include "tb_video_model.svh"

   tb_clkgen u_clkgen
   (
      .o_clk   (clk),
      .o_reset (reset)
   );

   ntsc_capture_top u_dut
   (
      .clk           (clk),
      .reset         (reset),
      .i_video       (video),
      .o_pair        (pair),
      .o_pair_valid  (pair_valid),
      .o_frame_start (frame_start)
   );

   bind ntsc_capture_top ntsc_capture_chk u_chk
   (
      .clk           (clk),
      .reset         (reset),
      .i_pair_valid  (o_pair_valid),
      .i_frame_start (o_frame_start)
   );

   //////////////////////////////////////////////////
   // Checks and scoreboard
   //////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_pair(input pair_word_t got);
      pair_word_t exp;
      got_pairs++;
      assert (exp_q.size() != 0)
      else
      begin
         $display("Unexpected pair at t=%0t with no pair predicted", $time);
         errors++;
      end
      if (exp_q.size() != 0)
      begin
         exp = exp_q.pop_front();
         check_value("o_pair.pix0", 64'(got.pix0), 64'(exp.pix0));
         check_value("o_pair.pix1", 64'(got.pix1), 64'(exp.pix1));
         check_value("o_pair.col", 64'(got.col), 64'(exp.col));
         check_value("o_pair.line", 64'(got.line), 64'(exp.line));
      end
      // Nothing from the right border may leak out
      assert (got.col < `ACTIVE_COLS)
      else
      begin
         $display("Pair at t=%0t carries column %0d outside the window", $time, got.col);
         errors++;
      end
   endtask

   // Outputs sampled on the edge and stable since the previous one
   always @(posedge clk)
   begin
      if (!reset)
      begin
         if (frame_start)
         begin
            got_markers++;
         end
         if (pair_valid)
         begin
            check_pair(pair);
         end
      end
   end

   //////////////////////////////////////////////////
   // Stream builders
   //////////////////////////////////////////////////

   task automatic send_word(input logic [9:0] w);
      @(posedge clk);
      video <= w;
   endtask

   // Preamble plus XY with the model updated ahead of the DUT
   task automatic send_code(input logic [9:0] xy);
      model_code(xy);
      send_word(`CODE_FF);
      send_word(`CODE_00);
      send_word(`CODE_00);
      send_word(xy);
   endtask

   // Abort index below zero means a clean line
   task automatic send_line(input logic f, input int n, input int abort_at);
      logic [9:0] w;
      logic       aborted;
      aborted = 1'b0;
      send_code(f ? `XY_SAV_F2 : `XY_SAV_F1);
      for (int k = 0; k < 2 * n; k++)
      begin
         w = rand_data();
         if (k == abort_at)
         begin
            aborted = 1'b1;
            send_word(`CODE_FF);
         end
         else
         begin
            if (!aborted)
            begin
               model_word(k, w);
            end
            send_word(w);
         end
      end
      send_code(f ? `XY_EAV_F2 : `XY_EAV_F1);
   endtask

   // Vertical line, then active lines of random even length
   task automatic send_field(input logic f, input int lines, input bit wide,
                             input bit aborts);
      int n;
      int abort_at;
      send_code(f ? `XY_SAV_VBI_F2 : `XY_SAV_VBI_F1);
      for (int k = 0; k < 4; k++)
      begin
         send_word(rand_data());
      end
      send_code(f ? `XY_EAV_VBI_F2 : `XY_EAV_VBI_F1);
      for (int i = 0; i < lines; i++)
      begin
         n = 2 * rand_range(2, 10);
         if (wide && (i == lines - 1))
         begin
            n = 700;
         end
         abort_at = -1;
         if (aborts && (i % 3 == 2))
         begin
            abort_at = rand_range(0, 2 * n - 1);
         end
         send_line(f, n, abort_at);
      end
   endtask

   // Drain predicted pairs, then print the test line
   task automatic end_test(input string name, input int err_start, input int pair_start);
      int n;
      n = 0;
      while ((exp_q.size() != 0) && (n < 2000))
      begin
         @(posedge clk);
         n++;
      end
      n = 0;
      while (n < 8)
      begin
         @(posedge clk);
         n++;
      end
      assert (exp_q.size() == 0)
      else
      begin
         $display("Timed out with %0d predicted pairs never seen", exp_q.size());
         errors++;
         exp_q.delete();
      end
      check_value("o_frame_start count", 64'(got_markers), 64'(m_markers));
      tests_run++;
      if (errors != err_start)
      begin
         tests_failed++;
      end
      $display("test %s: %s, %0d pairs", name, (errors == err_start) ? "ok" : "errors",
               got_pairs - pair_start);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      int n;
      int e0;
      int p0;
      int m0;
      video = 10'h040;
      n = 0;
      while ((reset !== 1'b0) && (n < 100))
      begin
         @(posedge clk);
         n++;
      end
      assert (reset === 1'b0)
      else
      begin
         $display("Reset was never released");
         errors++;
      end

      // Field bit 0 puts the first window line at 26
      e0 = errors;
      p0 = got_pairs;
      send_field(1'b0, 20, 1'b0, 1'b0);
      end_test("field0_window", e0, p0);

      // Last line runs past column 640
      e0 = errors;
      p0 = got_pairs;
      send_field(1'b0, 20, 1'b1, 1'b0);
      end_test("wide_line", e0, p0);

      // Two f=1 fields in a row give one marker and f=0 re-arms
      e0 = errors;
      p0 = got_pairs;
      m0 = got_markers;
      send_field(1'b1, 2, 1'b0, 1'b0);
      send_field(1'b1, 2, 1'b0, 1'b0);
      send_field(1'b0, 2, 1'b0, 1'b0);
      send_field(1'b1, 2, 1'b0, 1'b0);
      check_value("frame markers in test", 64'(got_markers - m0), 64'd2);
      end_test("frame_marker", e0, p0);

      // 3FF dropped into every third line
      e0 = errors;
      p0 = got_pairs;
      send_field(1'b0, 20, 1'b0, 1'b1);
      send_field(1'b1, 20, 1'b0, 1'b1);
      end_test("mid_line_abort", e0, p0);

      // Field bit 1 gives odd lines starting at 25
      e0 = errors;
      p0 = got_pairs;
      send_field(1'b1, 20, 1'b0, 1'b0);
      end_test("field1_odd_lines", e0, p0);

      // Concurrent assertions of the bound checker
      assert (u_dut.u_chk.failures == 0)
      else
      begin
         $display("Bound assertions failed %0d times", u_dut.u_chk.failures);
         errors++;
      end

      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
